/* project.f */
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_addr_xlate.sv
verilog/ex_mem_req.sv
verilog/ex_stage.sv
sim/ex_stage_chk.sv
sim/ex_stage_tb.sv

/* sim/ex_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module ex_stage_tb;

    logic clk, reset, flush, ms_has_exc, wb_ex, ds_to_es_valid, es_allow_in;
    ex_pkg::word_t ds_pc, ds_rj_value, ds_rkd_value, ds_imm;
    ex_pkg::reg_idx_t ds_dest;
    logic ds_gr_we, ds_mem_we, ds_res_from_mem, ds_src1_is_pc, ds_src2_is_imm;
    ex_pkg::alu_op_t ds_alu_op;
    ex_pkg::st_op_t ds_st_op;
    ex_pkg::ld_op_t ds_ld_op;
    logic ds_rdcntvl, ds_rdcntvh;
    ex_pkg::exc_t ds_exc;
    logic ms_allow_in, es_to_ms_valid, es_gr_we, es_res_from_mem, es_mem_we;
    ex_pkg::word_t es_pc, es_result, es_vaddr;
    ex_pkg::reg_idx_t es_dest;
    ex_pkg::ld_op_t es_ld_op;
    ex_pkg::exc_t es_exc;
    logic data_sram_req, data_sram_wr, data_sram_addr_ok;
    ex_pkg::size_t data_sram_size;
    ex_pkg::strb_t data_sram_wstrb;
    ex_pkg::word_t data_sram_addr, data_sram_wdata;
    logic crmd_da, crmd_pg, dmw0_plv0, dmw0_plv3, dmw1_plv0, dmw1_plv3;
    ex_pkg::plv_t plv, tlb_plv;
    ex_pkg::mat_t datm, dmw0_mat, dmw1_mat;
    ex_pkg::seg_t dmw0_pseg, dmw0_vseg, dmw1_pseg, dmw1_vseg;
    logic [18:0] tlb_vppn;
    logic tlb_va_bit12, tlb_found, tlb_v, tlb_d;
    ex_pkg::ppn_t tlb_ppn;
    logic fwd_valid, fwd_gr_we, fwd_is_load;
    ex_pkg::reg_idx_t fwd_dest;
    ex_pkg::word_t fwd_result;

    // reference model state, mirrors the stage register
    logic m_valid = 1'b0;
    ex_pkg::word_t m_pc, m_rj, m_rkd, m_imm;
    ex_pkg::reg_idx_t m_dest;
    logic m_gr_we, m_mem_we, m_res_from_mem, m_src1_is_pc, m_src2_is_imm;
    ex_pkg::alu_op_t m_alu_op;
    ex_pkg::st_op_t m_st_op;
    ex_pkg::ld_op_t m_ld_op;
    logic m_rdcntvl, m_rdcntvh;
    ex_pkg::exc_t m_ds_exc;
    ex_pkg::count_t m_cnt = '0;     // cycles since reset fell
    ex_pkg::word_t e_alu, e_result, e_paddr;
    ex_pkg::exc_t e_exc;
    logic e_memop, e_req, e_ready_go, e_allow_in;
    int unsigned accepted = 0;      // taken from decode and not flushed on entry
    int unsigned flushed = 0;       // dropped by a flush before leaving
    int unsigned dut_handoffs = 0;
    ex_pkg::ld_op_t ld_kinds [5] = '{3'b000, 3'b001, 3'b010, 3'b101, 3'b110};

    ex_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // a failed bound assertion ends the run as well
    always @(dut0.chk0.fail_count) begin
        if (dut0.chk0.fail_count != 0) begin
            $display("assertion failed in the bound checker at %0t", $time);
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got=%h exp=%h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic ex_pkg::word_t exp_alu(input ex_pkg::alu_op_t op,
                                              input ex_pkg::word_t a, input ex_pkg::word_t b);
        case (1'b1)
            op[`EX_ALU_ADD]:  return a + b;
            op[`EX_ALU_SUB]:  return a - b;
            op[`EX_ALU_SLT]:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op[`EX_ALU_SLTU]: return (a < b) ? 32'd1 : 32'd0;
            op[`EX_ALU_AND]:  return a & b;
            op[`EX_ALU_NOR]:  return ~(a | b);
            op[`EX_ALU_OR]:   return a | b;
            op[`EX_ALU_XOR]:  return a ^ b;
            op[`EX_ALU_SLL]:  return a << b[4:0];
            op[`EX_ALU_SRL]:  return a >> b[4:0];
            op[`EX_ALU_SRA]:  return $signed(a) >>> b[4:0];
            op[`EX_ALU_LUI]:  return b;
            default:          return 32'd0;
        endcase
    endfunction

    function automatic logic window_hit(input logic p0, input logic p3, input ex_pkg::mat_t mat,
                                        input ex_pkg::seg_t vseg, input ex_pkg::word_t va);
        logic plv_ok;
        plv_ok = (plv == 2'd0) ? p0 : ((plv == 2'd3) ? p3 : 1'b0);
        return plv_ok && (datm == mat) && (va[31:29] == vseg);
    endfunction

    function automatic ex_pkg::word_t exp_paddr(input ex_pkg::word_t va);
        if (crmd_da && !crmd_pg)
            return va;
        if (!crmd_da && crmd_pg) begin
            if (window_hit(dmw0_plv0, dmw0_plv3, dmw0_mat, dmw0_vseg, va))
                return {dmw0_pseg, va[28:0]};
            if (window_hit(dmw1_plv0, dmw1_plv3, dmw1_mat, dmw1_vseg, va))
                return {dmw1_pseg, va[28:0]};
            return {tlb_ppn, va[11:0]};
        end
        return 32'd0;
    endfunction

    function automatic ex_pkg::exc_t exp_xlate_exc(input ex_pkg::word_t va, input logic rd,
                                                   input logic wr);
        if (crmd_da || !crmd_pg || !(rd || wr))
            return ex_pkg::exc_none;
        if (window_hit(dmw0_plv0, dmw0_plv3, dmw0_mat, dmw0_vseg, va)
                || window_hit(dmw1_plv0, dmw1_plv3, dmw1_mat, dmw1_vseg, va))
            return ex_pkg::exc_none;
        if (plv == 2'd3 && va[31])
            return ex_pkg::exc_adem;
        if (!tlb_found)
            return ex_pkg::exc_tlbr;
        if (!tlb_v)
            return wr ? ex_pkg::exc_pis : ex_pkg::exc_pil;
        if (plv > tlb_plv)
            return ex_pkg::exc_ppi;
        if (wr && !tlb_d)
            return ex_pkg::exc_pme;
        return ex_pkg::exc_none;
    endfunction

    function automatic ex_pkg::size_t exp_size(input logic wr, input ex_pkg::st_op_t st,
                                               input ex_pkg::ld_op_t ld);
        if (wr)
            return st[`EX_ST_W] ? `EX_SIZE_W : (st[`EX_ST_H] ? `EX_SIZE_H : `EX_SIZE_B);
        if (ld[`EX_LD_B])
            return `EX_SIZE_B;
        return ld[`EX_LD_H] ? `EX_SIZE_H : `EX_SIZE_W;
    endfunction

    function automatic ex_pkg::strb_t exp_wstrb(input ex_pkg::st_op_t st, input logic [1:0] lo);
        if (st[`EX_ST_W])
            return 4'b1111;
        if (st[`EX_ST_H])
            return lo[1] ? 4'b1100 : 4'b0011;
        case (lo)
            2'd0:    return 4'b0001;
            2'd1:    return 4'b0010;
            2'd2:    return 4'b0100;
            default: return 4'b1000;
        endcase
    endfunction

    function automatic ex_pkg::word_t exp_wdata(input ex_pkg::st_op_t st, input ex_pkg::word_t v);
        if (st[`EX_ST_B])
            return {v[7:0], v[7:0], v[7:0], v[7:0]};
        if (st[`EX_ST_H])
            return {v[15:0], v[15:0]};
        return v;
    endfunction

    // expected outputs from model state and the inputs of this cycle
    task automatic compute_expect();
        ex_pkg::word_t src1;
        ex_pkg::word_t src2;
        ex_pkg::size_t sz;
        ex_pkg::exc_t xe;
        logic mis;
        src1 = m_src1_is_pc ? m_pc : m_rj;
        src2 = m_src2_is_imm ? m_imm : m_rkd;
        e_alu = exp_alu(m_alu_op, src1, src2);
        e_memop = m_mem_we || m_res_from_mem;
        e_result = m_rdcntvl ? m_cnt[31:0] : (m_rdcntvh ? m_cnt[63:32] : e_alu);
        e_paddr = exp_paddr(e_alu);
        sz = exp_size(m_mem_we, m_st_op, m_ld_op);
        mis = e_memop && ((sz == `EX_SIZE_W && e_alu[1:0] != 2'b00)
                          || (sz == `EX_SIZE_H && e_alu[0]));
        xe = exp_xlate_exc(e_alu, m_res_from_mem, m_mem_we);
        if (m_ds_exc != ex_pkg::exc_none)
            e_exc = m_ds_exc;
        else if (xe == ex_pkg::exc_adem)
            e_exc = xe;
        else
            e_exc = mis ? ex_pkg::exc_ale : xe;
        e_req = m_valid && e_memop && ms_allow_in && (e_exc == ex_pkg::exc_none)
                && !ms_has_exc && !wb_ex;
        e_ready_go = (e_exc != ex_pkg::exc_none) || (e_memop ? (e_req && data_sram_addr_ok) : 1'b1);
        e_allow_in = !m_valid || (e_ready_go && ms_allow_in);
    endtask

    task automatic check_outputs();
        check_value("es_allow_in", es_allow_in, e_allow_in);
        check_value("es_to_ms_valid", es_to_ms_valid, m_valid && e_ready_go);
        check_value("data_sram_req", data_sram_req, e_req);
        check_value("fwd_valid", fwd_valid, m_valid);
        if (m_valid) begin
            check_value("es_pc", es_pc, m_pc);
            check_value("es_dest", es_dest, m_dest);
            check_value("es_gr_we", es_gr_we, m_gr_we && (e_exc == ex_pkg::exc_none));
            check_value("es_res_from_mem", es_res_from_mem, m_res_from_mem);
            check_value("es_mem_we", es_mem_we, m_mem_we);
            check_value("es_ld_op", es_ld_op, m_ld_op);
            check_value("es_result", es_result, e_result);
            check_value("es_vaddr", es_vaddr, e_alu);
            check_value("es_exc", es_exc, e_exc);
            check_value("tlb_vppn", tlb_vppn, e_alu[31:13]);
            check_value("tlb_va_bit12", tlb_va_bit12, e_alu[12]);
            check_value("fwd_gr_we", fwd_gr_we, m_gr_we);
            check_value("fwd_dest", fwd_dest, m_dest);
            check_value("fwd_is_load", fwd_is_load, m_res_from_mem);
            check_value("fwd_result", fwd_result, e_result);
            if (e_memop) begin
                check_value("data_sram_addr", data_sram_addr, e_paddr);
                check_value("data_sram_wr", data_sram_wr, m_mem_we);
                check_value("data_sram_size", data_sram_size,
                            exp_size(m_mem_we, m_st_op, m_ld_op));
            end
            if (m_mem_we) begin
                check_value("data_sram_wstrb", data_sram_wstrb, exp_wstrb(m_st_op, e_alu[1:0]));
                check_value("data_sram_wdata", data_sram_wdata, exp_wdata(m_st_op, m_rkd));
            end
        end
    endtask

    // next state, taken at the coming rising edge
    task automatic update_model();
        if (ds_to_es_valid && e_allow_in) begin
            m_pc = ds_pc;
            m_rj = ds_rj_value;
            m_rkd = ds_rkd_value;
            m_imm = ds_imm;
            m_dest = ds_dest;
            m_gr_we = ds_gr_we;
            m_mem_we = ds_mem_we;
            m_res_from_mem = ds_res_from_mem;
            m_alu_op = ds_alu_op;
            m_src1_is_pc = ds_src1_is_pc;
            m_src2_is_imm = ds_src2_is_imm;
            m_st_op = ds_st_op;
            m_ld_op = ds_ld_op;
            m_rdcntvl = ds_rdcntvl;
            m_rdcntvh = ds_rdcntvh;
            m_ds_exc = ds_exc;
        end
        if (reset || flush)
            m_valid = 1'b0;
        else if (e_allow_in)
            m_valid = ds_to_es_valid;
        m_cnt = reset ? 64'd0 : m_cnt + 64'd1;
    endtask

    always @(negedge clk) begin
        compute_expect();
        if (!reset) begin
            check_outputs();
            if (es_to_ms_valid && ms_allow_in)
                dut_handoffs++;
            if (ds_to_es_valid && es_allow_in && !flush)
                accepted++;
            if (flush && fwd_valid && !(es_to_ms_valid && ms_allow_in))
                flushed++;
        end
        update_model();
    end

    task automatic randomize_context();
        logic [31:0] r;
        r = $urandom;
        crmd_da = (r[1:0] == 2'd0) || (r[1:0] == 2'd3 && r[2]);    // both set is reserved
        crmd_pg = (r[1:0] == 2'd1) || (r[1:0] == 2'd2) || (r[1:0] == 2'd3 && r[2]);
        plv = r[3] ? 2'd3 : {1'b0, r[4] & r[5]};
        dmw0_plv0 = r[7];
        dmw0_plv3 = r[8];
        dmw0_mat = r[10:9];
        dmw0_pseg = r[13:11];
        dmw0_vseg = r[16:14];
        dmw1_plv0 = r[17];
        dmw1_plv3 = r[18];
        dmw1_mat = r[20:19];
        dmw1_pseg = r[23:21];
        dmw1_vseg = r[26:24];
        datm = r[27] ? (r[28] ? dmw0_mat : dmw1_mat) : r[30:29];
        r = $urandom;
        tlb_found = (r[2:0] != 3'd0);
        tlb_ppn = r[22:3];
        tlb_plv = r[24:23];
        tlb_v = (r[27:25] != 3'd0);
        tlb_d = (r[29:28] != 2'd0);
    endtask

    task automatic drive_random();
        logic [31:0] r;
        int unsigned kind;
        r = $urandom;
        flush = (r[5:0] == 6'd0);
        ms_has_exc = (r[10:6] == 5'd0);
        wb_ex = (r[15:11] == 5'd0);
        ms_allow_in = (r[17:16] != 2'd0);
        data_sram_addr_ok = (r[19:18] != 2'd0);
        ds_to_es_valid = (r[21:20] != 2'd0);
        ds_src1_is_pc = r[22];
        ds_src2_is_imm = r[23];
        ds_gr_we = r[24] | r[25];
        ds_dest = r[30:26];
        if (!(m_valid && (m_mem_we || m_res_from_mem)))
            randomize_context();    // translation inputs stay put under a pending access
        ds_pc = $urandom;
        ds_rj_value = $urandom;
        ds_rkd_value = $urandom;
        ds_imm = $urandom;
        ds_alu_op = 12'd1 << ($urandom % 12);
        ds_mem_we = 1'b0;
        ds_res_from_mem = 1'b0;
        ds_st_op = 3'b000;
        ds_ld_op = 3'b000;
        ds_rdcntvl = 1'b0;
        ds_rdcntvh = 1'b0;
        r = $urandom;
        ds_exc = ex_pkg::exc_none;
        if (r[3:0] == 4'd0)
            ds_exc = r[4] ? ex_pkg::exc_adef : ex_pkg::exc_ine;
        kind = $urandom % 10;
        if (kind == 5) begin
            ds_rdcntvl = r[5];
            ds_rdcntvh = !r[5];
        end else if (kind >= 6) begin
            ds_alu_op = 12'd1 << `EX_ALU_ADD;
            ds_src1_is_pc = 1'b0;
            ds_src2_is_imm = 1'b1;
            ds_rj_value[1:0] = 2'b00;
            ds_imm = r[6] ? 32'd0 : {30'd0, r[8:7]};    // low bits pick the lane
            if (r[9])
                ds_rj_value[31:29] = r[10] ? dmw0_vseg : dmw1_vseg;
            if (kind >= 8) begin
                ds_mem_we = 1'b1;
                ds_gr_we = 1'b0;
                ds_st_op = 3'b001 << ($urandom % 3);
            end else begin
                ds_res_from_mem = 1'b1;
                ds_ld_op = ld_kinds[$urandom % 5];
            end
        end
    endtask

    task automatic drive_idle();
        ds_to_es_valid = 1'b0;
        flush = 1'b0;
        ms_has_exc = 1'b0;
        wb_ex = 1'b0;
        ms_allow_in = 1'b1;
        data_sram_addr_ok = 1'b1;
    endtask

    initial begin
        int i;
        int waited;
        void'($urandom(32'h63c8_e587));
        reset = 1'b1;
        drive_random();
        drive_idle();
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;
        for (i = 0; i < 4000; i++) begin
            @(posedge clk);
            #2 drive_random();
        end
        @(posedge clk);
        #2 drive_idle();
        waited = 0;
        while (fwd_valid !== 1'b0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (fwd_valid !== 1'b0) begin
            $display("timeout: the stage never emptied after stimulus stopped");
            $display(">>> FAIL");
            $fatal(1, "drain timeout");
        end
        // every instruction taken in either left once or was flushed
        check_value("handoff_count", dut_handoffs, accepted - flushed);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/ex_stage_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stage_chk (
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,
    input  logic          es_valid,
    input  logic          es_to_ms_valid,
    input  logic          data_sram_req,
    input  logic          data_sram_wr,
    input  logic          data_sram_addr_ok,
    input  ex_pkg::word_t data_sram_addr,
    input  ex_pkg::size_t data_sram_size,
    input  ex_pkg::strb_t data_sram_wstrb
);

    int unsigned fail_count = 0;

    req_needs_valid: assert property (@(posedge clk) disable iff (reset)
        data_sram_req |-> es_valid)
        else begin
            fail_count++;
            $error("data_sram_req high with an empty stage");
        end

    // a flush drops the instruction, so the held request ends with it
    req_held_stable: assert property (@(posedge clk) disable iff (reset)
        data_sram_req && !data_sram_addr_ok && !flush |=>
            $stable(data_sram_addr) && $stable(data_sram_size)
            && $stable(data_sram_wstrb))
        else begin
            fail_count++;
            $error("pending request changed its address, size or strobe");
        end

    valid_low_after_reset: assert property (@(posedge clk)
        reset |=> !es_to_ms_valid)
        else begin
            fail_count++;
            $error("es_to_ms_valid high in the cycle after reset");
        end

    write_has_strobe: assert property (@(posedge clk) disable iff (reset)
        data_sram_req && data_sram_wr |-> data_sram_wstrb != 4'b0000)
        else begin
            fail_count++;
            $error("write request with an empty strobe");
        end

endmodule

bind ex_stage ex_stage_chk chk0 (
    .clk               (clk),
    .reset             (reset),
    .flush             (flush),
    .es_valid          (es_valid),
    .es_to_ms_valid    (es_to_ms_valid),
    .data_sram_req     (data_sram_req),
    .data_sram_wr      (data_sram_wr),
    .data_sram_addr_ok (data_sram_addr_ok),
    .data_sram_addr    (data_sram_addr),
    .data_sram_size    (data_sram_size),
    .data_sram_wstrb   (data_sram_wstrb)
);

`default_nettype wire

/* verilog/ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  logic              clk,
    input  logic              reset,

    input  logic              flush,
    input  logic              ms_has_exc,
    input  logic              wb_ex,

    input  logic              ds_to_es_valid,
    output logic              es_allow_in,
    input  ex_pkg::word_t     ds_pc,
    input  ex_pkg::word_t     ds_rj_value,
    input  ex_pkg::word_t     ds_rkd_value,
    input  ex_pkg::word_t     ds_imm,
    input  ex_pkg::reg_idx_t  ds_dest,
    input  logic              ds_gr_we,
    input  logic              ds_mem_we,
    input  logic              ds_res_from_mem,
    input  ex_pkg::alu_op_t   ds_alu_op,
    input  logic              ds_src1_is_pc,
    input  logic              ds_src2_is_imm,
    input  ex_pkg::st_op_t    ds_st_op,
    input  ex_pkg::ld_op_t    ds_ld_op,
    input  logic              ds_rdcntvl,
    input  logic              ds_rdcntvh,
    input  ex_pkg::exc_t      ds_exc,

    input  logic              ms_allow_in,
    output logic              es_to_ms_valid,
    output ex_pkg::word_t     es_pc,
    output logic              es_gr_we,
    output logic              es_res_from_mem,
    output logic              es_mem_we,
    output ex_pkg::reg_idx_t  es_dest,
    output ex_pkg::word_t     es_result,
    output ex_pkg::word_t     es_vaddr,
    output ex_pkg::ld_op_t    es_ld_op,
    output ex_pkg::exc_t      es_exc,

    output logic              data_sram_req,
    output logic              data_sram_wr,
    output ex_pkg::size_t     data_sram_size,
    output ex_pkg::strb_t     data_sram_wstrb,
    output ex_pkg::word_t     data_sram_addr,
    output ex_pkg::word_t     data_sram_wdata,
    input  logic              data_sram_addr_ok,

    input  logic              crmd_da,
    input  logic              crmd_pg,
    input  ex_pkg::plv_t      plv,
    input  ex_pkg::mat_t      datm,
    input  logic              dmw0_plv0,
    input  logic              dmw0_plv3,
    input  ex_pkg::mat_t      dmw0_mat,
    input  ex_pkg::seg_t      dmw0_pseg,
    input  ex_pkg::seg_t      dmw0_vseg,
    input  logic              dmw1_plv0,
    input  logic              dmw1_plv3,
    input  ex_pkg::mat_t      dmw1_mat,
    input  ex_pkg::seg_t      dmw1_pseg,
    input  ex_pkg::seg_t      dmw1_vseg,

    output logic [18:0]       tlb_vppn,
    output logic              tlb_va_bit12,
    input  logic              tlb_found,
    input  ex_pkg::ppn_t      tlb_ppn,
    input  ex_pkg::plv_t      tlb_plv,
    input  logic              tlb_v,
    input  logic              tlb_d,

    output logic              fwd_valid,
    output logic              fwd_gr_we,
    output ex_pkg::reg_idx_t  fwd_dest,
    output logic              fwd_is_load,
    output ex_pkg::word_t     fwd_result
);

    logic             es_valid;
    logic             es_ready_go;
    logic             mem_op;
    logic             misaligned;
    ex_pkg::exc_t     xlate_exc;
    ex_pkg::word_t    alu_result;
    ex_pkg::count_t   stable_cnt;

    // instruction fields held from decode
    ex_pkg::word_t    rj_value_q;
    ex_pkg::word_t    rkd_value_q;
    ex_pkg::word_t    imm_q;
    logic             gr_we_q;
    ex_pkg::alu_op_t  alu_op_q;
    logic             src1_is_pc_q;
    logic             src2_is_imm_q;
    ex_pkg::st_op_t   st_op_q;
    logic             rdcntvl_q;
    logic             rdcntvh_q;
    ex_pkg::exc_t     ds_exc_q;

    always_ff @(posedge clk) begin
        if (reset || flush)
            es_valid <= 1'b0;
        else if (es_allow_in)
            es_valid <= ds_to_es_valid;
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allow_in) begin
            es_pc           <= ds_pc;
            rj_value_q      <= ds_rj_value;
            rkd_value_q     <= ds_rkd_value;
            imm_q           <= ds_imm;
            es_dest         <= ds_dest;
            gr_we_q         <= ds_gr_we;
            es_mem_we       <= ds_mem_we;
            es_res_from_mem <= ds_res_from_mem;
            alu_op_q        <= ds_alu_op;
            src1_is_pc_q    <= ds_src1_is_pc;
            src2_is_imm_q   <= ds_src2_is_imm;
            st_op_q         <= ds_st_op;
            es_ld_op        <= ds_ld_op;
            rdcntvl_q       <= ds_rdcntvl;
            rdcntvh_q       <= ds_rdcntvh;
            ds_exc_q        <= ds_exc;
        end
    end

    // stable counter, free running from reset
    always_ff @(posedge clk) begin
        if (reset)
            stable_cnt <= '0;
        else
            stable_cnt <= stable_cnt + 64'd1;
    end

    ex_alu alu0 (
        .alu_op      (alu_op_q),
        .pc          (es_pc),
        .rj_value    (rj_value_q),
        .rkd_value   (rkd_value_q),
        .imm         (imm_q),
        .src1_is_pc  (src1_is_pc_q),
        .src2_is_imm (src2_is_imm_q),
        .alu_result  (alu_result)
    );

    ex_addr_xlate xlate0 (
        .vaddr        (es_vaddr),
        .mem_rd       (es_res_from_mem),
        .mem_wr       (es_mem_we),
        .crmd_da      (crmd_da),
        .crmd_pg      (crmd_pg),
        .plv          (plv),
        .datm         (datm),
        .dmw0_plv0    (dmw0_plv0),
        .dmw0_plv3    (dmw0_plv3),
        .dmw0_mat     (dmw0_mat),
        .dmw0_pseg    (dmw0_pseg),
        .dmw0_vseg    (dmw0_vseg),
        .dmw1_plv0    (dmw1_plv0),
        .dmw1_plv3    (dmw1_plv3),
        .dmw1_mat     (dmw1_mat),
        .dmw1_pseg    (dmw1_pseg),
        .dmw1_vseg    (dmw1_vseg),
        .tlb_found    (tlb_found),
        .tlb_ppn      (tlb_ppn),
        .tlb_plv      (tlb_plv),
        .tlb_v        (tlb_v),
        .tlb_d        (tlb_d),
        .paddr        (data_sram_addr),
        .tlb_vppn     (tlb_vppn),
        .tlb_va_bit12 (tlb_va_bit12),
        .xlate_exc    (xlate_exc)
    );

    ex_mem_req mreq0 (
        .vaddr_lo   (es_vaddr[1:0]),
        .st_op      (st_op_q),
        .ld_op      (es_ld_op),
        .mem_wr     (es_mem_we),
        .mem_rd     (es_res_from_mem),
        .rkd_value  (rkd_value_q),
        .size       (data_sram_size),
        .wstrb      (data_sram_wstrb),
        .wdata      (data_sram_wdata),
        .misaligned (misaligned)
    );

    assign es_vaddr  = alu_result;
    assign es_result = rdcntvl_q ? stable_cnt[31:0]
                     : (rdcntvh_q ? stable_cnt[63:32] : alu_result);

    // decode first, then adem ahead of ale, then the rest of the tlb checks
    always_comb begin
        if (ds_exc_q != ex_pkg::exc_none)
            es_exc = ds_exc_q;
        else if (xlate_exc == ex_pkg::exc_adem)
            es_exc = ex_pkg::exc_adem;
        else if (misaligned)
            es_exc = ex_pkg::exc_ale;
        else
            es_exc = xlate_exc;
    end

    assign es_gr_we = gr_we_q && (es_exc == ex_pkg::exc_none);

    assign mem_op        = es_res_from_mem | es_mem_we;
    assign data_sram_wr  = es_mem_we;
    assign data_sram_req = es_valid && mem_op && ms_allow_in
                        && (es_exc == ex_pkg::exc_none) && !ms_has_exc && !wb_ex;

    // a memory op leaves only once its address is taken
    assign es_ready_go    = (es_exc != ex_pkg::exc_none)
                         || (mem_op ? (data_sram_req && data_sram_addr_ok) : 1'b1);
    assign es_allow_in    = !es_valid || (es_ready_go && ms_allow_in);
    assign es_to_ms_valid = es_valid && es_ready_go;

    assign fwd_valid   = es_valid;
    assign fwd_gr_we   = gr_we_q;
    assign fwd_dest    = es_dest;
    assign fwd_is_load = es_res_from_mem;     // decode stalls on a load-use
    assign fwd_result  = es_result;

endmodule

`default_nettype wire

/* verilog/ex_mem_req.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module ex_mem_req (
    input  logic [1:0]     vaddr_lo,
    input  ex_pkg::st_op_t st_op,
    input  ex_pkg::ld_op_t ld_op,
    input  logic           mem_wr,
    input  logic           mem_rd,
    input  ex_pkg::word_t  rkd_value,
    output ex_pkg::size_t  size,
    output ex_pkg::strb_t  wstrb,
    output ex_pkg::word_t  wdata,
    output logic           misaligned
);

    logic is_word;
    logic is_half;

    // access width, shared by size and alignment
    assign is_word = (mem_wr & st_op[`EX_ST_W])
                   | (mem_rd & ~ld_op[`EX_LD_B] & ~ld_op[`EX_LD_H]);
    assign is_half = (mem_wr & st_op[`EX_ST_H])
                   | (mem_rd & ld_op[`EX_LD_H]);

    always_comb begin
        if (is_word)
            size = `EX_SIZE_W;
        else if (is_half)
            size = `EX_SIZE_H;
        else
            size = `EX_SIZE_B;     // byte loads and stores, and idle
    end

    assign misaligned = (is_word & (vaddr_lo != 2'b00))
                      | (is_half & vaddr_lo[0]);

    // sub-word data is replicated so every lane carries it
    always_comb begin
        wstrb = 4'b0000;
        wdata = rkd_value;
        if (mem_wr) begin
            if (st_op[`EX_ST_W]) begin
                wstrb = 4'b1111;
            end else if (st_op[`EX_ST_B]) begin
                wstrb = 4'b0001 << vaddr_lo;
                wdata = {4{rkd_value[7:0]}};
            end else if (st_op[`EX_ST_H]) begin
                wstrb = vaddr_lo[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rkd_value[15:0]}};
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/ex_addr_xlate.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module ex_addr_xlate (
    input  ex_pkg::word_t vaddr,
    input  logic          mem_rd,
    input  logic          mem_wr,
    input  logic          crmd_da,
    input  logic          crmd_pg,
    input  ex_pkg::plv_t  plv,
    input  ex_pkg::mat_t  datm,
    input  logic          dmw0_plv0,
    input  logic          dmw0_plv3,
    input  ex_pkg::mat_t  dmw0_mat,
    input  ex_pkg::seg_t  dmw0_pseg,
    input  ex_pkg::seg_t  dmw0_vseg,
    input  logic          dmw1_plv0,
    input  logic          dmw1_plv3,
    input  ex_pkg::mat_t  dmw1_mat,
    input  ex_pkg::seg_t  dmw1_pseg,
    input  ex_pkg::seg_t  dmw1_vseg,
    input  logic          tlb_found,
    input  ex_pkg::ppn_t  tlb_ppn,
    input  ex_pkg::plv_t  tlb_plv,
    input  logic          tlb_v,
    input  logic          tlb_d,
    output ex_pkg::word_t paddr,
    output logic [18:0]   tlb_vppn,
    output logic          tlb_va_bit12,
    output ex_pkg::exc_t  xlate_exc
);

    logic          direct_mode;
    logic          mapped_mode;
    logic          dmw0_hit;
    logic          dmw1_hit;
    logic          page_mode;
    ex_pkg::word_t dmw0_addr;
    ex_pkg::word_t dmw1_addr;
    ex_pkg::word_t page_addr;

    assign direct_mode = crmd_da & ~crmd_pg;
    assign mapped_mode = ~crmd_da & crmd_pg;

    assign dmw0_hit = ((plv == 2'd0 && dmw0_plv0) || (plv == 2'd3 && dmw0_plv3))
                    && datm == dmw0_mat && vaddr[31:`EX_SEG_LSB] == dmw0_vseg;
    assign dmw1_hit = ((plv == 2'd0 && dmw1_plv0) || (plv == 2'd3 && dmw1_plv3))
                    && datm == dmw1_mat && vaddr[31:`EX_SEG_LSB] == dmw1_vseg;

    assign dmw0_addr = {dmw0_pseg, vaddr[`EX_SEG_LSB-1:0]};
    assign dmw1_addr = {dmw1_pseg, vaddr[`EX_SEG_LSB-1:0]};
    assign page_addr = {tlb_ppn, vaddr[`EX_PAGE_BITS-1:0]};

    assign page_mode = mapped_mode & ~dmw0_hit & ~dmw1_hit;   // falls through to tlb

    // tlb compares on the even/odd page pair, bit 12 picks the half
    assign tlb_vppn     = vaddr[31:`EX_PAGE_BITS+1];
    assign tlb_va_bit12 = vaddr[`EX_PAGE_BITS];

    always_comb begin
        if (direct_mode)
            paddr = vaddr;
        else if (mapped_mode)
            paddr = dmw0_hit ? dmw0_addr : (dmw1_hit ? dmw1_addr : page_addr);
        else
            paddr = '0;     // reserved da/pg combination
    end

    always_comb begin
        xlate_exc = ex_pkg::exc_none;
        if (page_mode && (mem_rd || mem_wr)) begin
            if (plv == 2'd3 && vaddr[31])
                xlate_exc = ex_pkg::exc_adem;   // user touching kernel half
            else if (!tlb_found)
                xlate_exc = ex_pkg::exc_tlbr;
            else if (!tlb_v)
                xlate_exc = mem_wr ? ex_pkg::exc_pis : ex_pkg::exc_pil;
            else if (plv > tlb_plv)
                xlate_exc = ex_pkg::exc_ppi;
            else if (mem_wr && !tlb_d)
                xlate_exc = ex_pkg::exc_pme;
        end
    end

endmodule

`default_nettype wire

/* verilog/ex_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module ex_alu (
    input  ex_pkg::alu_op_t alu_op,
    input  ex_pkg::word_t   pc,
    input  ex_pkg::word_t   rj_value,
    input  ex_pkg::word_t   rkd_value,
    input  ex_pkg::word_t   imm,
    input  logic            src1_is_pc,
    input  logic            src2_is_imm,
    output ex_pkg::word_t   alu_result
);

    ex_pkg::word_t src1;
    ex_pkg::word_t src2;
    ex_pkg::word_t add_sub_res;
    ex_pkg::word_t sll_res;
    ex_pkg::word_t srl_res;
    ex_pkg::word_t sra_res;
    logic          use_sub;
    logic          carry;
    logic          slt_res;
    logic          sltu_res;

    assign src1 = src1_is_pc  ? pc  : rj_value;
    assign src2 = src2_is_imm ? imm : rkd_value;

    // one adder for add, sub and both compares
    assign use_sub = alu_op[`EX_ALU_SUB] | alu_op[`EX_ALU_SLT] | alu_op[`EX_ALU_SLTU];
    assign {carry, add_sub_res} = {1'b0, src1} + {1'b0, use_sub ? ~src2 : src2}
                                + {32'd0, use_sub};

    // signs differ: src1 negative wins, else sign of the difference
    assign slt_res  = (src1[31] & ~src2[31])
                    | (~(src1[31] ^ src2[31]) & add_sub_res[31]);
    assign sltu_res = ~carry;     // borrow out

    assign sll_res = src1 << src2[4:0];
    assign srl_res = src1 >> src2[4:0];
    assign sra_res = $signed(src1) >>> src2[4:0];

    assign alu_result =
          ({32{alu_op[`EX_ALU_ADD] | alu_op[`EX_ALU_SUB]}} & add_sub_res)
        | ({32{alu_op[`EX_ALU_SLT]}}  & {31'd0, slt_res})
        | ({32{alu_op[`EX_ALU_SLTU]}} & {31'd0, sltu_res})
        | ({32{alu_op[`EX_ALU_AND]}}  & (src1 & src2))
        | ({32{alu_op[`EX_ALU_NOR]}}  & ~(src1 | src2))
        | ({32{alu_op[`EX_ALU_OR]}}   & (src1 | src2))
        | ({32{alu_op[`EX_ALU_XOR]}}  & (src1 ^ src2))
        | ({32{alu_op[`EX_ALU_SLL]}}  & sll_res)
        | ({32{alu_op[`EX_ALU_SRL]}}  & srl_res)
        | ({32{alu_op[`EX_ALU_SRA]}}  & sra_res)
        | ({32{alu_op[`EX_ALU_LUI]}}  & src2);     // imm already shifted by decode

endmodule

`default_nettype wire

/* verilog/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;     // data, address, pc
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] alu_op_t;   // one-hot
    typedef logic [2:0]  st_op_t;    // one-hot: word, byte, half
    typedef logic [2:0]  ld_op_t;    // byte, half, unsigned; zero is word
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [2:0]  seg_t;
    typedef logic [19:0] ppn_t;
    typedef logic [1:0]  size_t;     // 0 byte, 1 half, 2 word
    typedef logic [3:0]  strb_t;
    typedef logic [63:0] count_t;

    // one encoded exception per instruction
    typedef enum logic [3:0] {
        exc_none = 4'd0,
        exc_adef = 4'd1,    // fetch address error, from decode
        exc_ine  = 4'd2,    // unknown instruction, from decode
        exc_adem = 4'd3,    // memory address error
        exc_ale  = 4'd4,    // misaligned access
        exc_tlbr = 4'd5,    // tlb refill
        exc_pil  = 4'd6,    // load page invalid
        exc_pis  = 4'd7,    // store page invalid
        exc_ppi  = 4'd8,    // page privilege
        exc_pme  = 4'd9     // page modified
    } exc_t;

endpackage

`default_nettype wire

/* verilog/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// one-hot ALU operation bits
`define EX_ALU_ADD   0
`define EX_ALU_SUB   1
`define EX_ALU_SLT   2
`define EX_ALU_SLTU  3
`define EX_ALU_AND   4
`define EX_ALU_NOR   5
`define EX_ALU_OR    6
`define EX_ALU_XOR   7
`define EX_ALU_SLL   8
`define EX_ALU_SRL   9
`define EX_ALU_SRA   10
`define EX_ALU_LUI   11

// store kind is one-hot, load kind is all zero for a word
`define EX_ST_W      0
`define EX_ST_B      1
`define EX_ST_H      2
`define EX_LD_B      0
`define EX_LD_H      1
`define EX_LD_U      2

`define EX_SEG_LSB   29     // window segment is vaddr[31:29]
`define EX_PAGE_BITS 12     // 4 KiB pages

`define EX_SIZE_B    2'd0
`define EX_SIZE_H    2'd1
`define EX_SIZE_W    2'd2

`endif
